// File: hw/mips_ctrl_consts.svh
`ifndef MIPS_CTRL_CONSTS_SVH
`define MIPS_CTRL_CONSTS_SVH

`define OPCODE_W     6
`define FUNCT_W      6
`define STATE_W      6
`define ALU_OP_W     3
`define SHIFT_OP_W   3
`define MEM_TO_REG_W 3

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Opcode field
`define OPC_RTYPE 6'b000000
`define OPC_ADDI  6'b001000
`define OPC_ADDIU 6'b001001
`define OPC_BEQ   6'b000100
`define OPC_BNE   6'b000101
`define OPC_BLE   6'b000110
`define OPC_BGT   6'b000111
`define OPC_SB    6'b101000
`define OPC_SH    6'b101001
`define OPC_SW    6'b101011
`define OPC_J     6'b000010
`define OPC_JAL   6'b000011

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Funct field of R-type instructions
`define FN_SLL  6'b000000
`define FN_SRL  6'b000010
`define FN_SRA  6'b000011
`define FN_SLLV 6'b000100
`define FN_SRAV 6'b000111
`define FN_JR   6'b001000
`define FN_ADD  6'b100000
`define FN_SUB  6'b100010
`define FN_AND  6'b100100
`define FN_SLT  6'b101010

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shifter commands
`define SH_NOP  3'd0
`define SH_LOAD 3'd1
`define SH_SLL  3'd2
`define SH_SRL  3'd3
`define SH_SRA  3'd4

`endif

// File: hw/isa_pkg.sv
`include "mips_ctrl_consts.svh"

package isa_pkg;

	typedef enum logic [`OPCODE_W-1:0] {
		OP_RTYPE = `OPC_RTYPE,
		OP_ADDI  = `OPC_ADDI,
		OP_ADDIU = `OPC_ADDIU,
		OP_BEQ   = `OPC_BEQ,
		OP_BNE   = `OPC_BNE,
		OP_BLE   = `OPC_BLE,
		OP_BGT   = `OPC_BGT,
		OP_SB    = `OPC_SB,
		OP_SH    = `OPC_SH,
		OP_SW    = `OPC_SW,
		OP_J     = `OPC_J,
		OP_JAL   = `OPC_JAL
	} opcode_t;

	typedef enum logic [`FUNCT_W-1:0] {
		FN_SLL  = `FN_SLL,
		FN_SRL  = `FN_SRL,
		FN_SRA  = `FN_SRA,
		FN_SLLV = `FN_SLLV,
		FN_SRAV = `FN_SRAV,
		FN_JR   = `FN_JR,
		FN_ADD  = `FN_ADD,
		FN_SUB  = `FN_SUB,
		FN_AND  = `FN_AND,
		FN_SLT  = `FN_SLT
	} funct_t;

	// One class per distinct path through the FSM
	typedef enum logic [3:0] {
		CLS_ADD,
		CLS_SUB,
		CLS_AND,
		CLS_SLT,
		CLS_SHIFT_IMM, // Amount from shamt
		CLS_SHIFT_VAR, // Amount from rs
		CLS_ADDI,
		CLS_ADDIU,
		CLS_BR_EQ, // beq, bne
		CLS_BR_GT, // bgt, ble
		CLS_STORE,
		CLS_JUMP,
		CLS_JAL,
		CLS_JR,
		CLS_NONE
	} instr_class_t;

	typedef enum logic [1:0] {
		SIZE_NONE = 2'd0,
		SIZE_WORD = 2'd1,
		SIZE_HALF = 2'd2,
		SIZE_BYTE = 2'd3
	} store_size_t;

endpackage

// File: hw/ctrl_pkg.sv
`include "mips_ctrl_consts.svh"

package ctrl_pkg;

	import isa_pkg::*;

	typedef enum logic [`STATE_W-1:0] {
		ST_FETCH1      = 6'd1,
		ST_FETCH2      = 6'd2,
		ST_FETCH3      = 6'd3,
		ST_DEC1        = 6'd4,
		ST_DEC2        = 6'd5,
		ST_ADD         = 6'd6,
		ST_SUB         = 6'd7,
		ST_AND         = 6'd8,
		ST_ADD_SUB_AND = 6'd9,
		ST_SHIFT_SHAMT = 6'd10,
		ST_SLL_SLLV    = 6'd11,
		ST_SRA_SRAV    = 6'd12,
		ST_SRL         = 6'd13,
		ST_SHIFT_REG   = 6'd14,
		ST_SHIFT_WB    = 6'd15,
		ST_SLT         = 6'd16,
		ST_ADDI_ADDIU  = 6'd17,
		ST_ADDI        = 6'd18,
		ST_ADDIU       = 6'd19,
		ST_BEQ_BNE1    = 6'd20,
		ST_BEQ_BNE2    = 6'd21,
		ST_BLE_BGT1    = 6'd22,
		ST_BLE_BGT2    = 6'd23,
		ST_STORE1      = 6'd24,
		ST_STORE2      = 6'd25,
		ST_STORE3      = 6'd26,
		ST_SW          = 6'd27,
		ST_SH          = 6'd28,
		ST_SB          = 6'd29,
		ST_JR          = 6'd31,
		ST_JAL1        = 6'd33,
		ST_JAL2        = 6'd34,
		ST_JUMP        = 6'd35,
		ST_CLOSE_WRITE = 6'd36
	} state_t;

	typedef enum logic [`ALU_OP_W-1:0] {
		ALU_LOAD = 3'd0,
		ALU_ADD  = 3'd1,
		ALU_SUB  = 3'd2,
		ALU_AND  = 3'd3,
		ALU_CMP  = 3'd7 // Sets the eq/gt/lt flags
	} alu_op_t;

	typedef enum logic [`SHIFT_OP_W-1:0] {
		SHIFT_NOP  = `SH_NOP,
		SHIFT_LOAD = `SH_LOAD,
		SHIFT_SLL  = `SH_SLL,
		SHIFT_SRL  = `SH_SRL,
		SHIFT_SRA  = `SH_SRA
	} shift_op_t;

	typedef enum logic [1:0] {
		REG_DST_RT = 2'd0,
		REG_DST_RA = 2'd1,
		REG_DST_RD = 2'd3
	} reg_dst_t;

	typedef enum logic [`MEM_TO_REG_W-1:0] {
		M2R_ALU_OUT = 3'd0,
		M2R_COMPARE = 3'd4,
		M2R_SHIFTER = 3'd5
	} mem_to_reg_t;

	typedef struct packed {
		logic ir_write;
		logic pc_write;
		logic memory_write;
		logic reg_write;
		logic a_b_write;
		logic [1:0] i_or_d;
		logic mem_data_write;
		logic [1:0] pc_source;
		logic alu_src_a;
		alu_op_t alu_op;
		logic alu_out_write;
		logic [1:0] alu_src_b;
		mem_to_reg_t mem_to_reg;
		reg_dst_t reg_dst;
		logic shift_src;
		shift_op_t shift_op;
		store_size_t store_size;
		logic [1:0] shift_amount_sel;
	} ctrl_word_t;

endpackage

// File: hw/instr_info_if.sv
`include "mips_ctrl_consts.svh"

interface instr_info_if import isa_pkg::*; ();

	instr_class_t instr_class;
	logic [`SHIFT_OP_W-1:0] shift_op; // Shift kind in the shifter encoding
	store_size_t store_size;
	logic branch_invert; // Taken on the flag being low

	modport decoder (
		output instr_class,
		output shift_op,
		output store_size,
		output branch_invert
	);

	modport consumer (
		input instr_class,
		input shift_op,
		input store_size,
		input branch_invert
	);

endinterface

// File: hw/instr_decoder.sv
`include "mips_ctrl_consts.svh"

module instr_decoder import isa_pkg::*; (
	input opcode_t i_op_code,
	input funct_t i_funct,
	instr_info_if.decoder info
);

	always_comb begin
		info.instr_class = CLS_NONE;
		info.shift_op = `SH_NOP;
		info.store_size = SIZE_NONE;
		info.branch_invert = 1'b0;

		case (i_op_code)
			OP_RTYPE: begin
				case (i_funct)
					FN_ADD: info.instr_class = CLS_ADD;
					FN_SUB: info.instr_class = CLS_SUB;
					FN_AND: info.instr_class = CLS_AND;
					FN_SLT: info.instr_class = CLS_SLT;
					FN_JR: info.instr_class = CLS_JR;
					FN_SLL: begin
						info.instr_class = CLS_SHIFT_IMM;
						info.shift_op = `SH_SLL;
					end
					FN_SRL: begin
						info.instr_class = CLS_SHIFT_IMM;
						info.shift_op = `SH_SRL;
					end
					FN_SRA: begin
						info.instr_class = CLS_SHIFT_IMM;
						info.shift_op = `SH_SRA;
					end
					FN_SLLV: begin
						info.instr_class = CLS_SHIFT_VAR;
						info.shift_op = `SH_SLL;
					end
					FN_SRAV: begin
						info.instr_class = CLS_SHIFT_VAR;
						info.shift_op = `SH_SRA;
					end
					default: info.instr_class = CLS_NONE; // Unknown funct closes at once
				endcase
			end
			OP_ADDI: info.instr_class = CLS_ADDI;
			OP_ADDIU: info.instr_class = CLS_ADDIU;
			OP_BEQ: info.instr_class = CLS_BR_EQ;
			OP_BNE: begin
				info.instr_class = CLS_BR_EQ;
				info.branch_invert = 1'b1;
			end
			OP_BGT: info.instr_class = CLS_BR_GT;
			OP_BLE: begin
				info.instr_class = CLS_BR_GT;
				info.branch_invert = 1'b1;
			end
			OP_SW: begin
				info.instr_class = CLS_STORE;
				info.store_size = SIZE_WORD;
			end
			OP_SH: begin
				info.instr_class = CLS_STORE;
				info.store_size = SIZE_HALF;
			end
			OP_SB: begin
				info.instr_class = CLS_STORE;
				info.store_size = SIZE_BYTE;
			end
			OP_J: info.instr_class = CLS_JUMP;
			OP_JAL: info.instr_class = CLS_JAL;
			default: info.instr_class = CLS_NONE;
		endcase
	end

endmodule

// File: hw/ctrl_sequencer.sv
module ctrl_sequencer import isa_pkg::*, ctrl_pkg::*; (
	input logic clock,
	input logic reset,
	instr_info_if.consumer info,
	output state_t o_state
);

	state_t next_state;

	always_ff @(posedge clock) begin
		if (reset) begin
			o_state <= ST_FETCH1;
		end else begin
			o_state <= next_state;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Next state
	always_comb begin
		next_state = ST_CLOSE_WRITE;

		case (o_state)
			ST_FETCH1: next_state = ST_FETCH2;
			ST_FETCH2: next_state = ST_FETCH3;
			ST_FETCH3: next_state = ST_DEC1;
			ST_DEC1: next_state = ST_DEC2;
			ST_DEC2: begin
				case (info.instr_class)
					CLS_ADD: next_state = ST_ADD;
					CLS_SUB: next_state = ST_SUB;
					CLS_AND: next_state = ST_AND;
					CLS_SLT: next_state = ST_SLT;
					CLS_SHIFT_IMM: next_state = ST_SHIFT_SHAMT;
					CLS_SHIFT_VAR: next_state = ST_SHIFT_REG;
					CLS_ADDI, CLS_ADDIU: next_state = ST_ADDI_ADDIU;
					CLS_BR_EQ: next_state = ST_BEQ_BNE1;
					CLS_BR_GT: next_state = ST_BLE_BGT1;
					CLS_STORE: next_state = ST_STORE1;
					CLS_JUMP: next_state = ST_JUMP;
					CLS_JAL: next_state = ST_JAL1;
					CLS_JR: next_state = ST_JR;
					default: next_state = ST_CLOSE_WRITE; // Undecoded
				endcase
			end
			ST_ADD, ST_SUB, ST_AND: next_state = ST_ADD_SUB_AND;
			ST_SHIFT_SHAMT, ST_SHIFT_REG: begin
				case (shift_op_t'(info.shift_op))
					SHIFT_SLL: next_state = ST_SLL_SLLV;
					SHIFT_SRL: next_state = ST_SRL;
					SHIFT_SRA: next_state = ST_SRA_SRAV;
					default: next_state = ST_CLOSE_WRITE;
				endcase
			end
			ST_SLL_SLLV, ST_SRL, ST_SRA_SRAV: next_state = ST_SHIFT_WB;
			ST_ADDI_ADDIU: begin
				next_state = (info.instr_class == CLS_ADDIU) ? ST_ADDIU : ST_ADDI;
			end
			ST_BEQ_BNE1: next_state = ST_BEQ_BNE2;
			ST_BLE_BGT1: next_state = ST_BLE_BGT2;
			ST_STORE1: next_state = ST_STORE2;
			ST_STORE2: next_state = ST_STORE3;
			ST_STORE3: begin
				case (info.store_size)
					SIZE_HALF: next_state = ST_SH;
					SIZE_BYTE: next_state = ST_SB;
					default: next_state = ST_SW;
				endcase
			end
			ST_JAL1: next_state = ST_JAL2;
			ST_JAL2: next_state = ST_JUMP;
			ST_CLOSE_WRITE: next_state = ST_FETCH1;
			ST_ADD_SUB_AND, ST_SHIFT_WB, ST_SLT, ST_ADDI, ST_ADDIU,
			ST_BEQ_BNE2, ST_BLE_BGT2, ST_SW, ST_SH, ST_SB,
			ST_JR, ST_JUMP: next_state = ST_CLOSE_WRITE;
			default: next_state = ST_FETCH1; // Recover from an illegal code
		endcase
	end

endmodule

// File: hw/ctrl_word_gen.sv
module ctrl_word_gen import isa_pkg::*, ctrl_pkg::*; (
	input logic clock,
	input logic reset,
	input state_t i_state,
	instr_info_if.consumer info,
	input logic i_greater,
	input logic i_equal,
	output ctrl_word_t o_ctrl
);

	ctrl_word_t word;
	logic branch_flag;
	logic branch_taken;

	assign branch_flag = (info.instr_class == CLS_BR_GT) ? i_greater : i_equal;
	assign branch_taken = branch_flag ^ info.branch_invert; // bne and ble invert

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Word for the current state
	always_comb begin
		word = '0;

		case (i_state)
			ST_FETCH1, ST_FETCH2, ST_FETCH3: begin
				word.alu_op = ALU_ADD; // PC + 4
				word.alu_src_b = 2'b01;
				word.pc_write = (i_state == ST_FETCH2);
				word.ir_write = (i_state == ST_FETCH3);
			end
			ST_DEC1: begin
				word.alu_op = ALU_ADD; // Branch target into alu_out
				word.a_b_write = 1'b1;
				word.alu_src_b = 2'b11;
				word.alu_out_write = 1'b1;
			end
			ST_DEC2: word.alu_op = ALU_ADD;
			ST_ADD, ST_SUB, ST_AND: begin
				word.alu_src_a = 1'b1;
				word.alu_out_write = 1'b1;
				case (i_state)
					ST_SUB: word.alu_op = ALU_SUB;
					ST_AND: word.alu_op = ALU_AND;
					default: word.alu_op = ALU_ADD;
				endcase
			end
			ST_ADD_SUB_AND: begin
				word.reg_write = 1'b1;
				word.reg_dst = REG_DST_RD;
			end
			ST_SHIFT_SHAMT: begin
				word.shift_op = SHIFT_LOAD;
				word.shift_src = 1'b1;
				word.shift_amount_sel = 2'b10; // Amount from shamt
			end
			ST_SHIFT_REG: word.shift_op = SHIFT_LOAD;
			ST_SLL_SLLV: word.shift_op = SHIFT_SLL;
			ST_SRL: word.shift_op = SHIFT_SRL;
			ST_SRA_SRAV: word.shift_op = SHIFT_SRA;
			ST_SHIFT_WB: begin
				word.reg_write = 1'b1;
				word.mem_to_reg = M2R_SHIFTER;
				word.reg_dst = REG_DST_RD;
			end
			ST_SLT: begin
				word.alu_op = ALU_CMP;
				word.alu_src_a = 1'b1;
				word.reg_write = 1'b1;
				word.mem_to_reg = M2R_COMPARE;
				word.reg_dst = REG_DST_RD;
			end
			ST_ADDI_ADDIU: begin
				word.alu_src_a = 1'b1;
				word.alu_src_b = 2'b10; // Sign-extended immediate
				word.alu_op = ALU_ADD;
				word.alu_out_write = 1'b1;
			end
			ST_ADDI: begin
				word.alu_src_a = 1'b1;
				word.alu_src_b = 2'b10;
				word.alu_out_write = 1'b1;
				word.reg_write = 1'b1;
				word.reg_dst = REG_DST_RT;
			end
			ST_ADDIU: begin
				word.reg_write = 1'b1;
				word.reg_dst = REG_DST_RT;
			end
			ST_BEQ_BNE1, ST_BEQ_BNE2, ST_BLE_BGT1, ST_BLE_BGT2: begin
				word.alu_src_a = 1'b1;
				word.alu_op = ALU_CMP;
				word.pc_source = 2'b01; // Target from alu_out
				word.i_or_d = (i_state inside {ST_BLE_BGT1, ST_BLE_BGT2}) ? 2'b01 : 2'b00;
				word.pc_write = (i_state inside {ST_BEQ_BNE2, ST_BLE_BGT2}) && branch_taken;
			end
			ST_STORE1, ST_STORE2, ST_STORE3: begin
				word.alu_src_a = 1'b1;
				word.alu_src_b = 2'b10;
				word.alu_op = ALU_ADD; // Effective address
				word.i_or_d = 2'b01;
				word.alu_out_write = (i_state == ST_STORE1);
				word.mem_data_write = (i_state == ST_STORE3);
			end
			ST_SW, ST_SH, ST_SB: begin
				word.memory_write = 1'b1;
				word.i_or_d = 2'b01;
				word.alu_op = ALU_ADD;
				case (i_state)
					ST_SH: word.store_size = SIZE_HALF;
					ST_SB: word.store_size = SIZE_BYTE;
					default: word.store_size = SIZE_WORD;
				endcase
			end
			ST_JR: begin
				word.pc_write = 1'b1;
				word.alu_src_a = 1'b1; // rs passes through the ALU
			end
			ST_JAL1: word.alu_out_write = 1'b1; // Return address
			ST_JAL2: begin
				word.reg_write = 1'b1;
				word.mem_to_reg = M2R_ALU_OUT;
				word.reg_dst = REG_DST_RA;
			end
			ST_JUMP: begin
				word.pc_source = 2'b10;
				word.pc_write = 1'b1;
			end
			default: word = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			o_ctrl <= '0;
		end else begin
			o_ctrl <= word;
		end
	end

endmodule

// File: hw/ctrl_unit.sv
module ctrl_unit import isa_pkg::*, ctrl_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input opcode_t i_op_code,
	input funct_t i_funct,
	input logic i_greater,
	input logic i_equal,

	output logic o_ir_write,
	output logic o_pc_write,
	output logic o_memory_write,
	output logic o_reg_write,
	output logic o_a_b_write,
	output logic [1:0] o_i_or_d,
	output logic o_mem_data_write,
	output logic [1:0] o_pc_source,
	output logic o_alu_src_a,
	output alu_op_t o_alu_op,
	output logic o_alu_out_write,
	output logic [1:0] o_alu_src_b,
	output mem_to_reg_t o_mem_to_reg,
	output reg_dst_t o_reg_dst,
	output logic o_shift_src,
	output shift_op_t o_shift_op,
	output store_size_t o_store_size,
	output logic [1:0] o_shift_amount_sel
);

	instr_info_if info ();

	state_t state;
	ctrl_word_t ctrl;

	instr_decoder u_decoder (
		.i_op_code (i_op_code),
		.i_funct   (i_funct),
		.info      (info.decoder)
	);

	ctrl_sequencer u_sequencer (
		.clock   (i_clock),
		.reset   (i_reset),
		.info    (info.consumer),
		.o_state (state)
	);

	ctrl_word_gen u_word_gen (
		.clock     (i_clock),
		.reset     (i_reset),
		.i_state   (state),
		.info      (info.consumer),
		.i_greater (i_greater),
		.i_equal   (i_equal),
		.o_ctrl    (ctrl)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Control word onto the datapath ports
	assign o_ir_write = ctrl.ir_write;
	assign o_pc_write = ctrl.pc_write;
	assign o_memory_write = ctrl.memory_write;
	assign o_reg_write = ctrl.reg_write;
	assign o_a_b_write = ctrl.a_b_write;
	assign o_i_or_d = ctrl.i_or_d;
	assign o_mem_data_write = ctrl.mem_data_write;
	assign o_pc_source = ctrl.pc_source;
	assign o_alu_src_a = ctrl.alu_src_a;
	assign o_alu_op = ctrl.alu_op;
	assign o_alu_out_write = ctrl.alu_out_write;
	assign o_alu_src_b = ctrl.alu_src_b;
	assign o_mem_to_reg = ctrl.mem_to_reg;
	assign o_reg_dst = ctrl.reg_dst;
	assign o_shift_src = ctrl.shift_src;
	assign o_shift_op = ctrl.shift_op;
	assign o_store_size = ctrl.store_size;
	assign o_shift_amount_sel = ctrl.shift_amount_sel;

endmodule

// File: testbench/tb_ctrl_unit.sv
module tb_ctrl_unit import isa_pkg::*, ctrl_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int COLS = 12;
	localparam int MAX_INSTR = 64;
	localparam int TIMEOUT = 40;

	logic clock;
	logic reset;
	opcode_t op_code;
	funct_t funct;
	logic greater;
	logic equal;

	logic o_ir_write;
	logic o_pc_write;
	logic o_memory_write;
	logic o_reg_write;
	logic o_a_b_write;
	logic [1:0] o_i_or_d;
	logic o_mem_data_write;
	logic [1:0] o_pc_source;
	logic o_alu_src_a;
	alu_op_t o_alu_op;
	logic o_alu_out_write;
	logic [1:0] o_alu_src_b;
	mem_to_reg_t o_mem_to_reg;
	reg_dst_t o_reg_dst;
	logic o_shift_src;
	shift_op_t o_shift_op;
	store_size_t o_store_size;
	logic [1:0] o_shift_amount_sel;

	logic [7:0] data [0:MAX_INSTR*COLS-1];
	int errors = 0;
	int checks = 0;
	int timeouts = 0;

	ctrl_unit dut (
		.i_clock (clock), .i_reset (reset), .i_op_code (op_code), .i_funct (funct),
		.i_greater (greater), .i_equal (equal),
		.o_ir_write (o_ir_write), .o_pc_write (o_pc_write),
		.o_memory_write (o_memory_write), .o_reg_write (o_reg_write),
		.o_a_b_write (o_a_b_write), .o_i_or_d (o_i_or_d),
		.o_mem_data_write (o_mem_data_write), .o_pc_source (o_pc_source),
		.o_alu_src_a (o_alu_src_a), .o_alu_op (o_alu_op),
		.o_alu_out_write (o_alu_out_write), .o_alu_src_b (o_alu_src_b),
		.o_mem_to_reg (o_mem_to_reg), .o_reg_dst (o_reg_dst), .o_shift_src (o_shift_src),
		.o_shift_op (o_shift_op), .o_store_size (o_store_size),
		.o_shift_amount_sel (o_shift_amount_sel)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Helpers
	task automatic step_cycle();
		@(posedge clock);
		#0.5; // Registered outputs settled and inputs change here
	endtask

	task automatic check_value(input string name, input int got, input int expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("[ERROR] %0.1f ns %s: got %0d, expected %0d", $realtime, name, got,
				expected);
		end
	endtask

	function automatic int all_outputs();
		return int'({o_ir_write, o_pc_write, o_memory_write, o_reg_write, o_a_b_write,
			o_i_or_d, o_mem_data_write, o_pc_source, o_alu_src_a, o_alu_op, o_alu_out_write,
			o_alu_src_b, o_mem_to_reg, o_reg_dst, o_shift_src, o_shift_op, o_store_size,
			o_shift_amount_sel});
	endfunction

	task automatic apply_reset();
		for (int i = 0; i < 10; i++) begin
			step_cycle();
			check_value("all outputs in reset", all_outputs(), 0);
		end
		reset = 1'b0;
		check_value("all outputs after reset", all_outputs(), 0);
	endtask

	task automatic wait_first_fetch();
		int edges;
		edges = 0;
		while (!o_ir_write && edges < TIMEOUT) begin
			step_cycle();
			edges++;
		end
		if (!o_ir_write) begin
			timeouts++;
			$display("no ir_write within %0d cycles after reset", TIMEOUT);
		end else begin
			check_value("o_ir_write latency after reset", edges, 3);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// One instruction, from its ir_write to the next one
	task automatic run_instruction(input int idx);
		int base;
		int cycles;
		int pc_writes;
		int reg_writes;
		int mem_writes;
		int data_writes;
		int mem_cycle;
		int data_cycle;
		int got_reg_dst;
		int got_mem_to_reg;
		int got_size;
		int got_alu_op;
		int got_shift_op;
		int exp_stores;
		string tag;
		base = idx * COLS;
		tag = $sformatf(", instr %0d", idx);
		cycles = 0;
		pc_writes = 0;
		reg_writes = 0;
		mem_writes = 0;
		data_writes = 0;
		mem_cycle = 0;
		data_cycle = 0;
		got_reg_dst = 0;
		got_mem_to_reg = 0;
		got_size = 0;
		got_alu_op = 0;
		got_shift_op = 0;
		op_code = opcode_t'(data[base][5:0]);
		funct = funct_t'(data[base+1][5:0]);
		greater = data[base+2][0];
		equal = data[base+3][0];
		do begin
			if (o_pc_write) pc_writes++;
			if (o_reg_write) begin
				reg_writes++;
				got_reg_dst = int'(o_reg_dst);
				got_mem_to_reg = int'(o_mem_to_reg);
			end
			if (o_memory_write) begin
				mem_writes++;
				mem_cycle = cycles;
				got_size = int'(o_store_size);
			end
			if (o_mem_data_write) begin
				data_writes++;
				data_cycle = cycles;
			end
			if (o_alu_out_write) got_alu_op = int'(o_alu_op); // Last pulse is the op state
			if (o_shift_op inside {SHIFT_SLL, SHIFT_SRL, SHIFT_SRA}) begin
				got_shift_op = int'(o_shift_op);
			end
			step_cycle();
			cycles++;
		end while (!o_ir_write && cycles < TIMEOUT);
		if (!o_ir_write) begin
			timeouts++;
			$display("instruction %0d stalled: no ir_write within %0d cycles", idx, TIMEOUT);
		end else begin
			exp_stores = (data[base+9] != 8'h00) ? 1 : 0;
			check_value({"cycles between o_ir_write", tag}, cycles, int'(data[base+4]));
			check_value({"o_pc_write pulses", tag}, pc_writes, int'(data[base+5]));
			check_value({"o_reg_write pulses", tag}, reg_writes, int'(data[base+6]));
			if (data[base+6] != 8'h00) begin
				check_value({"o_reg_dst", tag}, got_reg_dst, int'(data[base+7]));
				check_value({"o_mem_to_reg", tag}, got_mem_to_reg, int'(data[base+8]));
			end
			check_value({"o_memory_write pulses", tag}, mem_writes, exp_stores);
			check_value({"o_mem_data_write pulses", tag}, data_writes, exp_stores);
			check_value({"o_store_size", tag}, got_size, int'(data[base+9]));
			if (exp_stores == 1) begin
				check_value({"o_mem_data_write lead", tag}, mem_cycle - data_cycle, 1);
			end
			if (data[base+10] == 8'h01) begin
				check_value({"o_alu_op", tag}, got_alu_op, int'(data[base+11]));
			end else if (data[base+10] == 8'h02) begin
				check_value({"o_shift_op", tag}, got_shift_op, int'(data[base+11]));
			end
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Main sequence
	initial begin
		int n;
		reset = 1'b1;
		op_code = OP_RTYPE;
		funct = FN_ADD;
		greater = 1'b0;
		equal = 1'b0;
		foreach (data[i]) data[i] = 8'hff; // Marks the end of the stimulus
		$readmemh("testbench/ctrl_input.txt", data);
		if (data[0] == 8'hff) begin
			errors++;
			$display("no instructions read from testbench/ctrl_input.txt");
		end
		apply_reset();
		wait_first_fetch();
		n = 0;
		while (timeouts == 0 && n < MAX_INSTR && data[n*COLS] != 8'hff) begin
			run_instruction(n);
			n++;
		end
		$display("instructions %0d, checks %0d, errors %0d, timeouts %0d", n, checks, errors,
			timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// File: list.f
+incdir+hw
hw/isa_pkg.sv
hw/ctrl_pkg.sv
hw/instr_info_if.sv
hw/instr_decoder.sv
hw/ctrl_sequencer.sv
hw/ctrl_word_gen.sv
hw/ctrl_unit.sv
testbench/tb_ctrl_unit.sv

// File: Makefile
# Verilator build and run for the control unit testbench
VERILATOR ?= verilator
TOP       ?= tb_ctrl_unit
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR LOG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/ctrl_input.txt
// Columns (hex): opcode funct greater equal cycles pc_writes reg_writes reg_dst mem_to_reg
// store_size op_kind (0 none, 1 alu_op, 2 shift_op) op_value
00 20 0 0 8 1 1 3 0 0 1 1 // add
00 22 0 0 8 1 1 3 0 0 1 2 // sub
00 24 0 0 8 1 1 3 0 0 1 3 // and
00 2a 0 0 7 1 1 3 4 0 0 0 // slt
00 00 0 0 9 1 1 3 5 0 2 2 // sll
00 02 0 0 9 1 1 3 5 0 2 3 // srl
00 03 0 0 9 1 1 3 5 0 2 4 // sra
00 04 0 0 9 1 1 3 5 0 2 2 // sllv
00 07 0 0 9 1 1 3 5 0 2 4 // srav
08 00 0 0 8 1 1 0 0 0 0 0 // addi
09 00 0 0 8 1 1 0 0 0 0 0 // addiu
04 00 0 1 8 2 0 0 0 0 0 0 // beq taken
04 00 1 0 8 1 0 0 0 0 0 0 // beq not taken
05 00 0 0 8 2 0 0 0 0 0 0 // bne taken
05 00 0 1 8 1 0 0 0 0 0 0 // bne not taken
07 00 1 0 8 2 0 0 0 0 0 0 // bgt taken
07 00 0 1 8 1 0 0 0 0 0 0 // bgt not taken
06 00 0 0 8 2 0 0 0 0 0 0 // ble taken
06 00 1 0 8 1 0 0 0 0 0 0 // ble not taken
2b 00 0 0 a 1 0 0 0 1 0 0 // sw
29 00 0 0 a 1 0 0 0 2 0 0 // sh
28 00 0 0 a 1 0 0 0 3 0 0 // sb
02 00 0 0 7 2 0 0 0 0 0 0 // j
03 00 0 0 9 2 1 1 0 0 0 0 // jal
00 08 0 0 7 2 0 0 0 0 0 0 // jr
3f 00 0 0 6 1 0 0 0 0 0 0 // undecoded opcode
00 3f 0 0 6 1 0 0 0 0 0 0 // undecoded funct
